// ==== dv/tbClock.sv ====
module tbClock (
  output logic o_clk,
  output logic o_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 50; // 100 ns clock
  localparam int RESET_CYCLES = 10;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0; // released on a rising edge
  end

endmodule

// ==== dv/usbCtrlChecker.sv ====
module usbCtrlChecker (
  input  logic                i_clk,
  input  logic                i_rst,
  input  usbCtrlPkg::outEpInT i_outEp,
  input  logic                i_outDataGet,
  input  usbCtrlPkg::inEpInT  i_inEp,
  input  usbCtrlPkg::inEpOutT i_inEpOut,
  input  usbStdPkg::usbAddrT  i_devAddr,
  input  usbStdPkg::usbByteT  i_expByte,     // reference byte at o_byteIdx
  input  logic [7:0]          i_expLen,      // bytes expected in this transfer
  input  logic                i_expStall,
  input  logic                i_expOutAck,   // done must line up with OUT ack
  input  usbStdPkg::usbAddrT  i_newAddr,
  input  logic                i_addrPending, // SET_ADDRESS in flight
  input  logic                i_xferEnd,     // closes the transfer
  output logic [7:0]          o_byteIdx,
  output int                  o_byteCount,
  output int                  o_errors
);
  timeunit 1ns;
  timeprecision 100ps;
  import usbStdPkg::*;
  import usbCtrlPkg::*;

  logic    inReset;  // reset sampled on the last edge
  logic    lastByte; // byte consumed one cycle ago
  logic    consumed;
  usbAddrT expAddr;
  int      doneCnt;
  int      stallCnt;

  assign consumed = i_inEpOut.dataPut && i_inEp.grant && i_inEp.dataFree; // IN handshake

  task automatic flagError(input string msg);
    $display("Fail at time %0t: %s", $time, msg);
    o_errors++;
  endtask

  initial begin
    o_byteIdx   = '0;
    o_byteCount = 0;
    o_errors    = 0;
    lastByte    = 1'b0;
    expAddr     = '0;
    doneCnt     = 0;
    stallCnt    = 0;
  end

  always @(posedge i_clk) inReset <= i_rst;

  // sampled mid cycle, everything settled
  always @(negedge i_clk) begin
    if (inReset) begin
      if (i_inEpOut.req !== 1'b0 || i_inEpOut.dataPut !== 1'b0 ||
          i_inEpOut.dataDone !== 1'b0 || i_inEpOut.stall !== 1'b0)
        flagError("IN endpoint outputs not idle after reset");
      if (i_devAddr !== '0) flagError("device address not zero after reset");
    end else if (!i_rst) begin
      if (i_devAddr !== expAddr)
        flagError($sformatf("devAddr %0d, expected %0d", i_devAddr, expAddr));
      if (i_outDataGet !== i_outEp.dataAvail)
        flagError("OUT dataGet does not follow dataAvail"); // request mirrors avail
      if (i_inEpOut.dataPut && i_expLen == 0) flagError("dataPut in a request without IN data");
      if (i_inEpOut.dataPut && !i_inEpOut.req) flagError("dataPut without req");
      if (i_inEpOut.req && o_byteIdx >= i_expLen)
        flagError($sformatf("req still high after %0d bytes", o_byteIdx)); // nothing left
      if (consumed) begin
        o_byteCount++;
        if (o_byteIdx >= i_expLen) begin
          flagError($sformatf("extra byte %0d beyond length %0d", o_byteIdx, i_expLen));
        end else if (i_inEpOut.data != i_expByte) begin
          flagError($sformatf("byte %0d is %02h, expected %02h",
                              o_byteIdx, i_inEpOut.data, i_expByte));
        end
        o_byteIdx++;
      end
      if (i_inEpOut.dataDone) begin
        doneCnt++;
        if (o_byteIdx != i_expLen)
          flagError($sformatf("dataDone after %0d bytes, expected %0d", o_byteIdx, i_expLen));
        if (i_expLen != 0 && !lastByte) flagError("dataDone not one cycle after last byte");
        if (i_expOutAck && !i_outEp.acked) flagError("dataDone not in the OUT ack cycle");
      end
      if (i_inEpOut.stall) stallCnt++;
      if (i_inEp.acked && i_addrPending) expAddr = i_newAddr; // visible next cycle
      if (i_xferEnd) begin
        if (doneCnt != (i_expStall ? 0 : 1))
          flagError($sformatf("%0d dataDone pulses in transfer", doneCnt));
        if (stallCnt != int'(i_expStall))
          flagError($sformatf("%0d stall pulses in transfer", stallCnt));
        if (o_byteIdx != i_expLen)
          flagError($sformatf("%0d bytes sent, expected %0d", o_byteIdx, i_expLen));
        o_byteIdx = '0;
        doneCnt   = 0;
        stallCnt  = 0;
      end
      lastByte = consumed;
    end
  end

endmodule

// ==== dv/usbCtrlTb.sv ====
module usbCtrlTb;
  timeunit 1ns;
  timeprecision 100ps;
  import usbStdPkg::*;
  import usbCtrlPkg::*;

  localparam int          NUM_XFERS       = 7;
  localparam int          CLK_PERIOD      = 100;
  localparam int          WATCHDOG_CYCLES = NUM_XFERS * 400 + 1000;
  localparam int          WAIT_LIMIT      = 400; // cycles allowed per DUT event
  localparam int unsigned SEED            = 32'h3c04_7aa2;

  logic       clk;
  logic       rst;
  logic       outGrant;
  logic       outAvail;
  logic       outSetup;
  usbByteT    outData;
  logic       outAcked;
  logic       inGrant;
  logic       inFree;
  logic       inAcked;
  outEpInT    outEp;
  inEpInT     inEp;
  inEpOutT    inEpOut;
  logic       outDataGet;
  usbAddrT    devAddr;
  usbByteT    expByte;
  logic [7:0] expLen;
  int         expOffset;   // table start of current descriptor
  logic       expStall;
  logic       expOutAck;
  logic       addrPending;
  usbAddrT    newAddr;
  logic       xferEnd;
  logic [7:0] byteIdx;
  int         byteCount;
  int         chkErrors;
  int         seqErrors;
  int         doneSeen;    // per transfer, cleared by the sequence
  int         stallSeen;

  assign outEp = '{grant: outGrant, dataAvail: outAvail, setup: outSetup,
                   data: outData, acked: outAcked};
  assign inEp  = '{grant: inGrant, dataFree: inFree, acked: inAcked};

  // descriptor bytes as the host expects them
  function automatic usbByteT descByte(input int offset);
    usbByteT descTable [50];
    descTable = '{
      8'd18, 8'd1, 8'h00, 8'h02, 8'd0, 8'd0, 8'd0, 8'd32, 8'h25, 8'h05, // device
      8'ha6, 8'ha4, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd1,
      8'd9, 8'd2, 8'd32, 8'd0, 8'd1, 8'd1, 8'd0, 8'hc0, 8'd50,         // configuration
      8'd9, 8'd4, 8'd0, 8'd0, 8'd2, 8'hff, 8'd0, 8'd0, 8'd0,           // interface
      8'd7, 8'd5, 8'h01, 8'd2, 8'd32, 8'd0, 8'd0,                      // bulk OUT
      8'd7, 8'd5, 8'h81, 8'd2, 8'd8, 8'd0, 8'd0                        // bulk IN
    };
    return (offset >= 0 && offset < 50) ? descTable[offset] : 8'h00;
  endfunction

  assign expByte = descByte(expOffset + int'(byteIdx));

  tbClock u_clock (.o_clk(clk), .o_rst(rst));

  usbCtrlSerial i_dut (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_outEp        (outEp),
    .o_outEpDataGet (outDataGet),
    .i_inEp         (inEp),
    .o_inEp         (inEpOut),
    .o_devAddr      (devAddr)
  );

  usbCtrlChecker u_checker (
    .i_clk(clk), .i_rst(rst), .i_outEp(outEp), .i_outDataGet(outDataGet),
    .i_inEp(inEp), .i_inEpOut(inEpOut),
    .i_devAddr(devAddr), .i_expByte(expByte), .i_expLen(expLen), .i_expStall(expStall),
    .i_expOutAck(expOutAck), .i_newAddr(newAddr), .i_addrPending(addrPending),
    .i_xferEnd(xferEnd), .o_byteIdx(byteIdx), .o_byteCount(byteCount), .o_errors(chkErrors)
  );

  always @(negedge clk) begin
    if (inEpOut.dataDone) doneSeen++;
    if (inEpOut.stall) stallSeen++;
  end

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic pulseAck(input bit inSide); // one cycle acked from the endpoint
    @(posedge clk);
    if (inSide) inAcked <= 1'b1;
    else        outAcked <= 1'b1;
    @(posedge clk);
    inAcked  <= 1'b0;
    outAcked <= 1'b0;
  endtask

  task automatic waitEvent(input bit forStall, input string what);
    int cycles;
    cycles = 0;
    while ((forStall ? stallSeen : doneSeen) == 0 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if ((forStall ? stallSeen : doneSeen) == 0) begin
      $display("Gave up at time %0t waiting for %s", $time, what);
      seqErrors++;
    end
  endtask

  // 8 setup bytes, data shows up the cycle after each grant
  task automatic sendSetup(input usbByteT reqType, input usbByteT req,
                           input logic [15:0] value, input logic [15:0] length);
    usbByteT pkt [8];
    int      sent;
    pkt = '{reqType, req, value[7:0], value[15:8], 8'h00, 8'h00, length[7:0], length[15:8]};
    sent = 0;
    doneSeen = 0;
    stallSeen = 0;
    @(posedge clk);
    outSetup <= 1'b1;
    outAvail <= 1'b1;
    outGrant <= 1'($urandom % 2);
    while (sent < 8) begin
      @(posedge clk);
      if (outAvail && outGrant) begin
        outData <= pkt[sent];
        sent++;
      end
      if (sent == 8) begin
        outAvail <= 1'b0;
        outGrant <= 1'b0;
      end else begin
        outGrant <= 1'($urandom % 2);
      end
    end
    @(posedge clk); // last byte stored on this edge
    outSetup <= 1'b0;
  endtask

  task automatic finishXfer();
    idle(2);
    @(posedge clk);
    xferEnd = 1'b1;
    @(posedge clk);
    xferEnd = 1'b0;
  endtask

  task automatic getDescriptor(input usbByteT descType, input logic [15:0] wLength);
    int descLen;
    descLen   = 0;
    expOffset = 0;
    if (descType == 8'd1) begin
      descLen = 18;
    end else if (descType == 8'd2) begin
      descLen   = 32;
      expOffset = 18;
    end
    expStall  = (descLen == 0); // other types stall
    expLen    = (descLen < wLength[7:0]) ? 8'(descLen) : wLength[7:0];
    expOutAck = 1'b0;
    sendSetup(8'h80, BREQUEST_GET_DESCRIPTOR, {descType, 8'h00}, wLength);
    if (expStall) begin
      waitEvent(1'b1, "stall pulse");
    end else begin
      waitEvent(1'b0, "IN data done");
      pulseAck(1'b1); // data stage
      pulseAck(1'b0); // status OUT
    end
    finishXfer();
  endtask

  task automatic setAddress(input usbAddrT addr);
    newAddr     = addr;
    addrPending = 1'b1;
    expLen      = 8'd0;
    expStall    = 1'b0;
    expOutAck   = 1'b0;
    sendSetup(8'h00, BREQUEST_SET_ADDRESS, {9'd0, addr}, 16'd0);
    waitEvent(1'b0, "zero length done");
    idle(1 + $urandom % 5); // old address must hold here
    pulseAck(1'b1);         // status IN
    finishXfer();
    addrPending = 1'b0;
  endtask

  task automatic outRequest(input logic [15:0] wLength);
    expLen    = 8'd0;
    expStall  = 1'b0;
    expOutAck = 1'b1;
    sendSetup(8'h21, 8'h20, 16'h0000, wLength); // class request, host to device
    idle(3);
    pulseAck(1'b0); // OUT data acked
    waitEvent(1'b0, "OUT data done");
    pulseAck(1'b1); // status IN
    finishXfer();
  endtask

  initial begin
    void'($urandom(SEED));
    outGrant    = 1'b0;
    outAvail    = 1'b0;
    outSetup    = 1'b0;
    outData     = '0;
    outAcked    = 1'b0;
    inGrant     = 1'b0;
    inFree      = 1'b0;
    inAcked     = 1'b0;
    expOffset   = 0;
    expLen      = '0;
    expStall    = 1'b0;
    expOutAck   = 1'b0;
    addrPending = 1'b0;
    newAddr     = '0;
    xferEnd     = 1'b0;
    seqErrors   = 0;
    doneSeen    = 0;
    stallSeen   = 0;
    fork
      forever begin // IN side back-pressure
        @(posedge clk);
        inGrant <= ($urandom % 4) != 0;
        inFree  <= ($urandom % 3) != 0;
      end
    join_none
    @(negedge rst);
    idle(3);
    getDescriptor(BDESCRIPTORTYPE_DEVICE, 16'd64);
    getDescriptor(BDESCRIPTORTYPE_CONFIGURATION, 16'd9);
    getDescriptor(BDESCRIPTORTYPE_CONFIGURATION, 16'd255);
    setAddress(7'(1 + $urandom % 127));
    getDescriptor(8'h03, 16'd64); // string type
    getDescriptor(BDESCRIPTORTYPE_DEVICE, 16'd64);
    outRequest(16'd7);
    idle(5);
    $display("Bytes checked %0d, checker errors %0d, sequence errors %0d",
             byteCount, chkErrors, seqErrors);
    if (chkErrors == 0 && seqErrors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/usbStdPkg.sv
verilog/usbCtrlPkg.sv
verilog/usbSetupCapture.sv
verilog/usbCtrlTransfer.sv
verilog/usbDescriptorRom.sv
verilog/usbCtrlSerial.sv
dv/tbClock.sv
dv/usbCtrlChecker.sv
dv/usbCtrlTb.sv

// ==== verilog/usbCtrlPkg.sv ====
package usbCtrlPkg;

  // control transfer stages
  typedef enum logic [2:0] {
    IDLE,       // waiting for a SETUP token
    SETUP,      // collecting the 8 setup bytes
    DATA_IN,    // device sends descriptor bytes
    DATA_OUT,   // host sends data, ignored here
    STATUS_IN,  // zero length IN handshake
    STATUS_OUT  // zero length OUT handshake
  } ctrlStageT;

  // decoded setup packet, fields little endian on the wire
  typedef struct packed {
    usbStdPkg::usbByteT bmRequestType; // bit 7 is direction, 1 = device to host
    usbStdPkg::usbByteT bRequest;
    logic [15:0]        wValue;        // descriptor type in high byte
    logic [15:0]        wIndex;
    logic [15:0]        wLength;       // only low byte used
  } setupPktT;

  // OUT endpoint, endpoint to engine
  typedef struct packed {
    logic               grant;
    logic               dataAvail;
    logic               setup;     // high from SETUP token until next OUT token
    usbStdPkg::usbByteT data;
    logic               acked;     // one cycle pulse
  } outEpInT;

  // IN endpoint, endpoint to engine
  typedef struct packed {
    logic grant;
    logic dataFree;
    logic acked;    // one cycle pulse
  } inEpInT;

  // IN endpoint, engine to endpoint
  typedef struct packed {
    logic               req;
    logic               dataPut;
    usbStdPkg::usbByteT data;
    logic               dataDone;
    logic               stall;
  } inEpOutT;

  typedef logic [6:0] romAddrT; // pointer into descriptor table

  // descriptor placement in the table
  localparam romAddrT DEV_DESC_OFFSET = 7'd0;
  localparam romAddrT CFG_DESC_OFFSET = 7'd18;
  localparam romAddrT DEV_DESC_LEN    = 7'd18;
  localparam romAddrT CFG_DESC_LEN    = 7'd32; // config + interface + 2 endpoints

  localparam logic [7:0] MAX_IN_PACKET_SIZE  = 8'd32;
  localparam logic [7:0] MAX_OUT_PACKET_SIZE = 8'd8;

  localparam int SETUP_BYTES = 8;

  // serial gadget identity
  localparam logic [15:0] VENDOR_ID  = 16'h0525;
  localparam logic [15:0] PRODUCT_ID = 16'ha4a6;

endpackage

// ==== verilog/usbCtrlSerial.sv ====
module usbCtrlSerial (
  input  logic                i_clk,
  input  logic                i_rst,
  input  usbCtrlPkg::outEpInT i_outEp,
  output logic                o_outEpDataGet,
  input  usbCtrlPkg::inEpInT  i_inEp,
  output usbCtrlPkg::inEpOutT o_inEp,
  output usbStdPkg::usbAddrT  o_devAddr
);
  import usbCtrlPkg::*;

  setupPktT  s_setup;
  logic      s_setupStart;     // SETUP packet begins
  logic      s_pktEnd;         // OUT packet finished
  ctrlStageT s_stage;
  logic      s_setupStageEnd;
  logic      s_statusStageEnd;
  logic      s_allDataSent;
  logic      s_zeroLenDone;    // done with no IN data
  logic      s_dataDoneIn;     // done after descriptor bytes

  assign o_outEpDataGet = i_outEp.dataAvail; // always drain the OUT endpoint

  usbSetupCapture u_setupCapture (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_outEp      (i_outEp),
    .o_setup      (s_setup),
    .o_setupStart (s_setupStart),
    .o_pktEnd     (s_pktEnd),
    .i_clear      (s_statusStageEnd)
  );

  usbCtrlTransfer u_ctrlTransfer (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_setup          (s_setup),
    .i_setupStart     (s_setupStart),
    .i_pktEnd         (s_pktEnd),
    .i_allDataSent    (s_allDataSent),
    .i_inAcked        (i_inEp.acked),
    .i_outAcked       (i_outEp.acked),
    .o_stage          (s_stage),
    .o_setupStageEnd  (s_setupStageEnd),
    .o_statusStageEnd (s_statusStageEnd),
    .o_zeroLenDone    (s_zeroLenDone),
    .o_stall          (o_inEp.stall),
    .o_devAddr        (o_devAddr)
  );

  usbDescriptorRom u_descriptorRom (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_setup          (s_setup),
    .i_stage          (s_stage),
    .i_setupStageEnd  (s_setupStageEnd),
    .i_statusStageEnd (s_statusStageEnd),
    .i_inEp           (i_inEp),
    .o_req            (o_inEp.req),
    .o_dataPut        (o_inEp.dataPut),
    .o_data           (o_inEp.data),
    .o_dataDoneIn     (s_dataDoneIn),
    .o_allDataSent    (s_allDataSent)
  );

  assign o_inEp.dataDone = s_dataDoneIn || s_zeroLenDone;

endmodule

// ==== verilog/usbCtrlTransfer.sv ====
module usbCtrlTransfer (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  usbCtrlPkg::setupPktT  i_setup,
  input  logic                  i_setupStart,
  input  logic                  i_pktEnd,
  input  logic                  i_allDataSent,
  input  logic                  i_inAcked,
  input  logic                  i_outAcked,
  output usbCtrlPkg::ctrlStageT o_stage,
  output logic                  o_setupStageEnd,
  output logic                  o_statusStageEnd,
  output logic                  o_zeroLenDone,
  output logic                  o_stall,
  output usbStdPkg::usbAddrT    o_devAddr
);
  import usbStdPkg::*;
  import usbCtrlPkg::*;

  ctrlStageT stage;
  ctrlStageT stageNext;
  logic      stall;        // one cycle stall pulse
  logic      saveDevAddr;  // SET_ADDRESS pending
  usbAddrT   newDevAddr;   // address waiting for status stage
  usbAddrT   devAddr;
  logic      hasDataStage;
  logic      hasInData;
  logic      hasOutData;
  logic      isGetDesc;
  logic      isSetAddr;
  logic      supportedDesc;
  usbByteT   descType;

  assign descType      = i_setup.wValue[15:8];
  assign isGetDesc     = (i_setup.bRequest == BREQUEST_GET_DESCRIPTOR);
  assign isSetAddr     = (i_setup.bRequest == BREQUEST_SET_ADDRESS);
  assign supportedDesc = (descType == BDESCRIPTORTYPE_DEVICE) ||
                         (descType == BDESCRIPTORTYPE_CONFIGURATION);

  assign hasDataStage = |i_setup.wLength[7:0]; // low byte only
  assign hasInData    = hasDataStage && i_setup.bmRequestType[7];
  assign hasOutData   = hasDataStage && !i_setup.bmRequestType[7];

  assign o_setupStageEnd = (stage == SETUP) && i_pktEnd;

  // a stalled IN data stage also ends the transfer
  assign o_statusStageEnd = ((stage == DATA_IN) && stall) ||
                            ((stage == STATUS_IN) && i_inAcked) ||
                            ((stage == STATUS_OUT) && i_outAcked);

  // zero length packet when no IN data goes out
  assign o_zeroLenDone = ((stage == SETUP) && i_pktEnd && !hasDataStage) ||
                         ((stage == DATA_OUT) && i_outAcked);

  always_comb begin
    stageNext = stage; // hold by default
    case (stage)
      IDLE: begin
        if (i_setupStart) stageNext = SETUP;
      end
      SETUP: begin
        if (i_pktEnd) begin
          if (hasInData) begin
            stageNext = DATA_IN;
          end else if (hasOutData) begin
            stageNext = DATA_OUT;
          end else begin
            stageNext = STATUS_IN; // no data stage
          end
        end
      end
      DATA_IN: begin
        if (stall) begin
          stageNext = IDLE; // abandon transfer
        end else if (i_inAcked && i_allDataSent) begin
          stageNext = STATUS_OUT;
        end
      end
      DATA_OUT: begin
        if (i_outAcked) stageNext = STATUS_IN;
      end
      STATUS_IN: begin
        if (i_inAcked) stageNext = IDLE;
      end
      STATUS_OUT: begin
        if (i_outAcked) stageNext = IDLE;
      end
      default: stageNext = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      stage       <= IDLE;
      stall       <= 1'b0;
      saveDevAddr <= 1'b0;
      devAddr     <= '0;
    end else begin
      stage <= stageNext;
      stall <= o_setupStageEnd && isGetDesc && !supportedDesc; // unknown type
      if (o_statusStageEnd && saveDevAddr) begin
        saveDevAddr <= 1'b0;
        devAddr     <= newDevAddr; // status token used the old address
      end else if (o_setupStageEnd && isSetAddr) begin
        saveDevAddr <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_setupStageEnd && isSetAddr) begin
      newDevAddr <= i_setup.wValue[6:0];
    end
  end

  assign o_stage   = stage;
  assign o_stall   = stall;
  assign o_devAddr = devAddr;

endmodule

// ==== verilog/usbDescriptorRom.sv ====
module usbDescriptorRom (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  usbCtrlPkg::setupPktT  i_setup,
  input  usbCtrlPkg::ctrlStageT i_stage,
  input  logic                  i_setupStageEnd,
  input  logic                  i_statusStageEnd,
  input  usbCtrlPkg::inEpInT    i_inEp,
  output logic                  o_req,
  output logic                  o_dataPut,
  output usbStdPkg::usbByteT    o_data,
  output logic                  o_dataDoneIn,
  output logic                  o_allDataSent
);
  import usbStdPkg::*;
  import usbCtrlPkg::*;

  romAddrT romAddr;    // read pointer
  romAddrT sentCnt;    // bytes consumed so far
  romAddrT romLength;  // selected descriptor length
  logic    allSent;
  logic    allSentLast; // rise detection
  logic    byteSent;
  logic    getDevDesc;
  logic    getCfgDesc;
  logic    inData;

  assign getDevDesc = (i_setup.bRequest == BREQUEST_GET_DESCRIPTOR) &&
                      (i_setup.wValue[15:8] == BDESCRIPTORTYPE_DEVICE);
  assign getCfgDesc = (i_setup.bRequest == BREQUEST_GET_DESCRIPTOR) &&
                      (i_setup.wValue[15:8] == BDESCRIPTORTYPE_CONFIGURATION);

  assign inData   = (i_stage == DATA_IN) && !allSent;
  assign byteSent = inData && i_inEp.grant && i_inEp.dataFree; // IN handshake

  // stop at descriptor end or at the host limit
  assign allSent = (sentCnt == romLength) ||
                   ({1'b0, sentCnt} == i_setup.wLength[7:0]);

  always_ff @(posedge i_clk) begin
    if (i_rst || i_statusStageEnd) begin
      romAddr   <= DEV_DESC_OFFSET;
      sentCnt   <= '0;
      romLength <= '0;
    end else begin
      if (byteSent) begin
        romAddr <= romAddr + 1'b1;
        sentCnt <= sentCnt + 1'b1;
      end else if (i_setupStageEnd) begin
        romAddr <= getCfgDesc ? CFG_DESC_OFFSET : DEV_DESC_OFFSET;
      end
      if (i_setupStageEnd) begin
        romLength <= getDevDesc ? DEV_DESC_LEN :
                     getCfgDesc ? CFG_DESC_LEN : '0; // unsupported sends nothing
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) allSentLast <= 1'b0;
    else       allSentLast <= allSent;
  end

  always_comb begin
    case (romAddr)
      // device descriptor
      7'd0:  o_data = {1'b0, DEV_DESC_LEN};    // bLength
      7'd1:  o_data = BDESCRIPTORTYPE_DEVICE;
      7'd2:  o_data = 8'h00;                   // bcdUSB 2.00
      7'd3:  o_data = 8'h02;
      7'd4:  o_data = BASECLASS_UNKNOWN;       // bDeviceClass
      7'd5:  o_data = 8'd0;                    // subclass
      7'd6:  o_data = 8'd0;                    // protocol
      7'd7:  o_data = MAX_IN_PACKET_SIZE;      // bMaxPacketSize0
      7'd8:  o_data = VENDOR_ID[7:0];
      7'd9:  o_data = VENDOR_ID[15:8];
      7'd10: o_data = PRODUCT_ID[7:0];
      7'd11: o_data = PRODUCT_ID[15:8];
      7'd17: o_data = 8'd1;                    // bNumConfigurations
      // configuration descriptor
      7'd18: o_data = 8'd9;
      7'd19: o_data = BDESCRIPTORTYPE_CONFIGURATION;
      7'd20: o_data = {1'b0, CFG_DESC_LEN};    // wTotalLength low
      7'd21: o_data = 8'd0;
      7'd22: o_data = 8'd1;                    // bNumInterfaces
      7'd23: o_data = 8'd1;                    // bConfigurationValue
      7'd25: o_data = 8'hc0;                   // self powered
      7'd26: o_data = 8'd50;                   // bMaxPower, 100 mA
      // interface descriptor
      7'd27: o_data = 8'd9;
      7'd28: o_data = BDESCRIPTORTYPE_INTERFACE;
      7'd31: o_data = 8'd2;                    // bNumEndpoints
      7'd32: o_data = BASECLASS_VENDOR;
      // bulk OUT endpoint 1
      7'd36: o_data = 8'd7;
      7'd37: o_data = BDESCRIPTORTYPE_ENDPOINT;
      7'd38: o_data = 8'h01;
      7'd39: o_data = ENDPTYPE_BULK;
      7'd40: o_data = MAX_IN_PACKET_SIZE;
      // bulk IN endpoint 1
      7'd43: o_data = 8'd7;
      7'd44: o_data = BDESCRIPTORTYPE_ENDPOINT;
      7'd45: o_data = 8'h81;                   // direction bit set
      7'd46: o_data = ENDPTYPE_BULK;
      7'd47: o_data = MAX_OUT_PACKET_SIZE;
      default: o_data = 8'd0;                  // zero fields and past table end
    endcase
  end

  assign o_req         = inData;
  assign o_dataPut     = inData && i_inEp.dataFree;
  assign o_allDataSent = allSent;
  assign o_dataDoneIn  = (i_stage == DATA_IN) && allSent && !allSentLast; // last byte out

endmodule

// ==== verilog/usbSetupCapture.sv ====
module usbSetupCapture (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  usbCtrlPkg::outEpInT  i_outEp,
  output usbCtrlPkg::setupPktT o_setup,
  output logic                 o_setupStart,
  output logic                 o_pktEnd,
  input  logic                 i_clear
);
  import usbStdPkg::*;
  import usbCtrlPkg::*;

  logic                           acceptValid;  // byte accepted last cycle
  logic                           dataAvailLast; // for edge detection
  logic [$clog2(SETUP_BYTES)-1:0] byteIdx;      // next byte slot
  usbByteT                        setupBytes [SETUP_BYTES];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      acceptValid   <= 1'b0;
      dataAvailLast <= 1'b0;
    end else begin
      acceptValid   <= i_outEp.dataAvail && i_outEp.grant; // OUT handshake
      dataAvailLast <= i_outEp.dataAvail;
    end
  end

  // byte index, cleared once the transfer is over
  always_ff @(posedge i_clk) begin
    if (i_rst || i_clear) begin
      byteIdx <= '0;
    end else if (i_outEp.setup && acceptValid) begin
      byteIdx <= byteIdx + 1'b1; // wraps after 8
    end
  end

  // data sampled one cycle after the handshake
  always_ff @(posedge i_clk) begin
    if (i_outEp.setup && acceptValid) begin
      setupBytes[byteIdx] <= i_outEp.data;
    end
  end

  assign o_setupStart = i_outEp.dataAvail && !dataAvailLast && i_outEp.setup; // rise
  assign o_pktEnd     = !i_outEp.dataAvail && dataAvailLast; // fall

  assign o_setup = '{
    bmRequestType: setupBytes[0],
    bRequest:      setupBytes[1],
    wValue:        {setupBytes[3], setupBytes[2]}, // low byte first
    wIndex:        {setupBytes[5], setupBytes[4]},
    wLength:       {setupBytes[7], setupBytes[6]}
  };

endmodule

// ==== verilog/usbStdPkg.sv ====
package usbStdPkg;

  typedef logic [7:0] usbByteT; // one byte on the bus
  typedef logic [6:0] usbAddrT; // device address set by the host

  // standard request codes, bRequest field
  localparam usbByteT BREQUEST_SET_ADDRESS    = 8'h05; // host assigns address
  localparam usbByteT BREQUEST_GET_DESCRIPTOR = 8'h06; // host reads a descriptor

  // descriptor types, high byte of wValue for GET_DESCRIPTOR
  localparam usbByteT BDESCRIPTORTYPE_DEVICE        = 8'h01;
  localparam usbByteT BDESCRIPTORTYPE_CONFIGURATION = 8'h02;
  localparam usbByteT BDESCRIPTORTYPE_INTERFACE     = 8'h04;
  localparam usbByteT BDESCRIPTORTYPE_ENDPOINT      = 8'h05;

  // class codes
  localparam usbByteT BASECLASS_UNKNOWN = 8'h00; // class defined per interface
  localparam usbByteT BASECLASS_VENDOR  = 8'hff; // vendor specific

  // endpoint transfer type, bmAttributes[1:0]
  localparam usbByteT ENDPTYPE_BULK = 8'h02;

endpackage
